// ==== bench/addrgen_checks.svh ====
`ifndef ADDRGEN_CHECKS_SVH
`define ADDRGEN_CHECKS_SVH

//////////////////////////////
// Compare tasks
//////////////////////////////

task automatic check_addr(addr_t got, addr_t exp, string what);
  if (got !== exp) begin
    report_error($sformatf("Fail at %0d ns: %s is 0x%h, expected 0x%h", $time, what, got, exp));
  end
endtask

task automatic check_len(axi_len_t got, axi_len_t exp, string what);
  if (got !== exp) begin
    report_error($sformatf("Fail at %0d ns: %s is %0d, expected %0d", $time, what, got, exp));
  end
endtask

task automatic check_size(axi_size_t got, axi_size_t exp, string what);
  if (got !== exp) begin
    report_error($sformatf("Fail at %0d ns: %s is %0d, expected %0d", $time, what, got, exp));
  end
endtask

task automatic check_bit(logic got, logic exp, string what);
  if (got !== exp) begin
    report_error($sformatf("Fail at %0d ns: %s is %b, expected %b", $time, what, got, exp));
  end
endtask

task automatic check_count(int got, int exp, string what);
  if (got != exp) begin
    report_error($sformatf("Fail at %0d ns: %s count is %0d, expected %0d",
                           $time, what, got, exp));
  end
endtask

task automatic compare_access(access_t got, access_t exp, string what);
  check_addr(got.addr, exp.addr, {what, " addr"});
  check_len(got.len, exp.len, {what, " len"});
  check_size(got.size, exp.size, {what, " size"});
  check_bit(got.is_load, exp.is_load, {what, " direction"});
endtask

// AR, AW and queue commands against the expected list, in order
task automatic check_issued();
  int n_load;
  int ar_i;
  int aw_i;
  n_load = 0;
  ar_i   = 0;
  aw_i   = 0;
  foreach (exp_log[i]) if (exp_log[i].is_load) n_load++;
  check_count(ar_log.size(), n_load, "AR request");
  check_count(aw_log.size(), exp_log.size() - n_load, "AW request");
  check_count(pop_log.size(), exp_log.size(), "LSU command");
  check_count(ack_count, insn_count, "ack");
  foreach (exp_log[i]) begin
    if (exp_log[i].is_load) begin
      compare_access(ar_log[ar_i], exp_log[i], "AR");
      ar_i++;
    end else begin
      compare_access(aw_log[aw_i], exp_log[i], "AW");
      aw_i++;
    end
    // Each command matches the same burst as its address request
    compare_access(pop_log[i], exp_log[i], "LSU command");
  end
endtask

task automatic finish_and_check();
  logic exc_v;
  logic exc_l;
  logic exc_s;
  wait_ack(exc_v, exc_l, exc_s);
  check_bit(exc_v, 1'b0, "exc_valid_o on a legal instruction");
  check_bit(exc_l, 1'b0, "exc_load_o on a legal instruction");
  check_bit(exc_s, 1'b0, "exc_store_o on a legal instruction");
  wait_drained();
  check_issued();
  check_bit(order_err, 1'b0, "direction ordering violation");
endtask

//////////////////////////////
// Directed tests
//////////////////////////////

task automatic test_reset_state();
  check_bit(pe_ready_o, 1'b1, "pe_ready_o after reset");
  check_bit(ar_valid_o, 1'b0, "ar_valid_o after reset");
  check_bit(aw_valid_o, 1'b0, "aw_valid_o after reset");
  check_bit(lsu_valid_o, 1'b0, "lsu_valid_o after reset");
  check_bit(ack_o, 1'b0, "ack_o after reset");
  check_bit(exc_valid_o, 1'b0, "exc_valid_o after reset");
  check_bit(exc_load_o, 1'b0, "exc_load_o after reset");
  check_bit(exc_store_o, 1'b0, "exc_store_o after reset");
endtask

task automatic test_unit_load();
  start_test("page-contained unit-stride load");
  expect_unit(32'h1000, 12'd16, EW32, 1'b1);
  send_insn(OP_UNIT_LOAD, 32'h1000, 12'd16, '0, EW32);
  finish_and_check();
  // One full-width burst of 8 beats
  check_len(ar_log[0].len, 8'd7, "single burst len");
  check_size(ar_log[0].size, 3'd3, "single burst size");
endtask

task automatic test_page_cross();
  start_test("page-crossing unit-stride store");
  expect_unit(32'h1FF0, 12'd8, EW64, 1'b0);
  send_insn(OP_UNIT_STORE, 32'h1FF0, 12'd8, '0, EW64);
  finish_and_check();
  // Split at the 4 KiB boundary
  check_len(aw_log[0].len, 8'd1, "first burst len");
  check_addr(aw_log[1].addr, 32'h2000, "second burst addr");
  check_len(aw_log[1].len, 8'd5, "second burst len");
endtask

task automatic test_burst_limit();
  start_test("256-beat burst limit");
  expect_unit(32'h0, 12'd512, EW64, 1'b1);
  send_insn(OP_UNIT_LOAD, 32'h0, 12'd512, '0, EW64);
  finish_and_check();
  check_len(ar_log[0].len, 8'd255, "first long burst len");
  check_len(ar_log[1].len, 8'd255, "second long burst len");
endtask

task automatic test_strided_pending();
  start_test("strided store behind pending scalar stores");
  expect_strided(32'h5000, 12'd4, EW16, 32'sd12, 1'b0);
  core_st_pending_i = 1'b1;
  send_insn(OP_STRIDED_STORE, 32'h5000, 12'd4, 32'sd12, EW16);
  wait_cycles(12);
  // Nothing may leave while stores drain
  check_count(aw_valid_cycles, 0, "AW valid cycles during store drain");
  core_st_pending_i = 1'b0;
  finish_and_check();
endtask

task automatic test_misaligned();
  logic exc_v;
  logic exc_l;
  logic exc_s;
  start_test("misaligned base address");
  send_insn(OP_UNIT_LOAD, 32'h1002, 12'd4, '0, EW32);
  wait_ack(exc_v, exc_l, exc_s);
  check_bit(exc_v, 1'b1, "exc_valid_o");
  check_bit(exc_l, 1'b1, "exc_load_o");
  check_bit(exc_s, 1'b0, "exc_store_o");
  wait_cycles(4);
  check_count(ar_valid_cycles, 0, "AR valid cycles");
  check_count(aw_valid_cycles, 0, "AW valid cycles");
  check_count(ack_count, 1, "ack");
endtask

task automatic test_ordering();
  logic exc_v;
  logic exc_l;
  logic exc_s;
  start_test("load then store direction ordering");
  lsu_enable = 1'b0;
  expect_unit(32'h3000, 12'd16, EW32, 1'b1);
  expect_unit(32'h4000, 12'd4, EW64, 1'b0);
  send_insn(OP_UNIT_LOAD, 32'h3000, 12'd16, '0, EW32);
  wait_ack(exc_v, exc_l, exc_s);
  check_bit(exc_v, 1'b0, "exc_valid_o on the load");
  check_bit(exc_l, 1'b0, "exc_load_o on the load");
  check_bit(exc_s, 1'b0, "exc_store_o on the load");
  send_insn(OP_UNIT_STORE, 32'h4000, 12'd4, '0, EW64);
  wait_cycles(10);
  // The load command still sits at the queue head
  check_count(aw_valid_cycles, 0, "AW valid cycles with loads queued");
  lsu_enable = 1'b1;
  finish_and_check();
endtask

`endif

// ==== bench/tb_vldst_addrgen.sv ====
module tb_vldst_addrgen;
  timeunit 1ns;
  timeprecision 1ps;
  import addrgen_pkg::*;

  localparam int unsigned AxiDataWidth = 64;
  localparam int unsigned QueueDepth   = 4;
  localparam int unsigned BeatBytes    = AxiDataWidth / 8;
  localparam int          ResetCycles  = 8;
  // Cycle limit for any single wait
  localparam int          WaitLimit    = 1000;
  // Beats per test: 8, 8, 512, 4, 0 and 8 + 4
  localparam int          TestBeats    = 544;
  localparam int          NumTests     = 6;
  localparam int          WatchdogCycles = ResetCycles + TestBeats + 200 * NumTests;

  // One address request or queue command
  typedef struct packed {
    addr_t     addr;
    axi_len_t  len;
    axi_size_t size;
    logic      is_load;
  } access_t;

  logic      clk_i = 1'b0;
  logic      rst_ni;
  mem_op_e   pe_op_i;
  addr_t     pe_addr_i;
  vl_t       pe_vl_i;
  stride_t   pe_stride_i;
  vew_e      pe_vew_i;
  logic      pe_valid_i;
  logic      pe_ready_o;
  addr_t     ar_addr_o;
  axi_len_t  ar_len_o;
  axi_size_t ar_size_o;
  logic      ar_valid_o;
  logic      ar_ready_i;
  addr_t     aw_addr_o;
  axi_len_t  aw_len_o;
  axi_size_t aw_size_o;
  logic      aw_valid_o;
  logic      aw_ready_i;
  addr_t     lsu_addr_o;
  axi_len_t  lsu_len_o;
  axi_size_t lsu_size_o;
  logic      lsu_is_load_o;
  logic      lsu_valid_o;
  logic      ldu_ready_i;
  logic      stu_ready_i;
  logic      ack_o;
  logic      exc_valid_o;
  logic      exc_load_o;
  logic      exc_store_o;
  logic      core_st_pending_i;

  // Logs filled by the monitor, expected list filled by the tests
  access_t ar_log[$];
  access_t aw_log[$];
  access_t pop_log[$];
  access_t exp_log[$];
  int      ack_count;
  int      insn_count;
  int      ar_valid_cycles;
  int      aw_valid_cycles;
  int      loads_queued;
  int      stores_queued;
  int      errors;
  logic    order_err  = 1'b0;
  // LSU model pops only while enabled
  logic    lsu_enable = 1'b1;
  integer  seed       = 96;

  vldst_addrgen #(
    .AxiDataWidth (AxiDataWidth),
    .QueueDepth   (QueueDepth)
  ) UUT (
    .clk_i (clk_i), .rst_ni (rst_ni),
    .pe_op_i (pe_op_i), .pe_addr_i (pe_addr_i), .pe_vl_i (pe_vl_i),
    .pe_stride_i (pe_stride_i), .pe_vew_i (pe_vew_i),
    .pe_valid_i (pe_valid_i), .pe_ready_o (pe_ready_o),
    .ar_addr_o (ar_addr_o), .ar_len_o (ar_len_o), .ar_size_o (ar_size_o),
    .ar_valid_o (ar_valid_o), .ar_ready_i (ar_ready_i),
    .aw_addr_o (aw_addr_o), .aw_len_o (aw_len_o), .aw_size_o (aw_size_o),
    .aw_valid_o (aw_valid_o), .aw_ready_i (aw_ready_i),
    .lsu_addr_o (lsu_addr_o), .lsu_len_o (lsu_len_o), .lsu_size_o (lsu_size_o),
    .lsu_is_load_o (lsu_is_load_o), .lsu_valid_o (lsu_valid_o),
    .ldu_ready_i (ldu_ready_i), .stu_ready_i (stu_ready_i),
    .ack_o (ack_o), .exc_valid_o (exc_valid_o),
    .exc_load_o (exc_load_o), .exc_store_o (exc_store_o),
    .core_st_pending_i (core_st_pending_i)
  );

  always #50 clk_i = ~clk_i;

  //////////////////////////////
  // Bus and LSU models
  //////////////////////////////

  // AR/AW slave, random ready from one stream
  initial begin
    logic [31:0] rnd;
    ar_ready_i = 1'b0;
    aw_ready_i = 1'b0;
    forever begin
      @(posedge clk_i);
      #10;
      rnd = $random(seed);
      ar_ready_i = rnd[0];
      aw_ready_i = rnd[1];
    end
  end

  // Load and store units, pop the head whenever enabled
  initial begin
    logic en;
    ldu_ready_i = 1'b0;
    stu_ready_i = 1'b0;
    forever begin
      @(posedge clk_i);
      en = lsu_enable;
      #10;
      ldu_ready_i = en && lsu_valid_o && lsu_is_load_o;
      stu_ready_i = en && lsu_valid_o && !lsu_is_load_o;
    end
  end

  function automatic access_t make_access(addr_t a, axi_len_t l, axi_size_t s, logic ld);
    access_t acc;
    acc.addr    = a;
    acc.len     = l;
    acc.size    = s;
    acc.is_load = ld;
    return acc;
  endfunction

  // Mid-cycle sampling, all handshakes here complete on the next rising edge
  always @(negedge clk_i) begin
    if (rst_ni) begin
      // Other direction still queued
      if (aw_valid_o && loads_queued != 0) order_err = 1'b1;
      if (ar_valid_o && stores_queued != 0) order_err = 1'b1;
      if (ar_valid_o) ar_valid_cycles++;
      if (aw_valid_o) aw_valid_cycles++;
      if (ar_valid_o && ar_ready_i) begin
        ar_log.push_back(make_access(ar_addr_o, ar_len_o, ar_size_o, 1'b1));
        loads_queued++;
      end
      if (aw_valid_o && aw_ready_i) begin
        aw_log.push_back(make_access(aw_addr_o, aw_len_o, aw_size_o, 1'b0));
        stores_queued++;
      end
      if (ldu_ready_i || stu_ready_i) begin
        pop_log.push_back(make_access(lsu_addr_o, lsu_len_o, lsu_size_o, lsu_is_load_o));
        if (lsu_is_load_o) loads_queued--;
        else stores_queued--;
      end
      if (ack_o) ack_count++;
    end
  end

  //////////////////////////////
  // Stimulus helpers
  //////////////////////////////

  task automatic report_error(input string line);
    errors++;
    $display("%s", line);
    $display("Some tests failed");
    $fatal(1, "Run stopped at the first error");
  endtask

  task automatic start_test(input string name);
    $display("Running test: %s", name);
    ar_log.delete();
    aw_log.delete();
    pop_log.delete();
    exp_log.delete();
    ack_count       = 0;
    insn_count      = 0;
    ar_valid_cycles = 0;
    aw_valid_cycles = 0;
    order_err       = 1'b0;
  endtask

  // Called and returns 10 ns after a rising edge
  task automatic send_insn(mem_op_e op, addr_t addr, vl_t vl, stride_t stride, vew_e vew);
    int waited;
    waited      = 0;
    pe_op_i     = op;
    pe_addr_i   = addr;
    pe_vl_i     = vl;
    pe_stride_i = stride;
    pe_vew_i    = vew;
    pe_valid_i  = 1'b1;
    @(negedge clk_i);
    while (!pe_ready_o) begin
      waited++;
      if (waited > WaitLimit) report_error("Timeout: the DUT never accepted the instruction");
      @(negedge clk_i);
    end
    @(posedge clk_i);
    #10;
    pe_valid_i = 1'b0;
    insn_count++;
  endtask

  task automatic wait_ack(output logic exc_v, output logic exc_l, output logic exc_s);
    int waited;
    waited = 0;
    @(negedge clk_i);
    while (!ack_o) begin
      waited++;
      if (waited > WaitLimit) report_error("Timeout: no acknowledge for the instruction");
      @(negedge clk_i);
    end
    exc_v = exc_valid_o;
    exc_l = exc_load_o;
    exc_s = exc_store_o;
    @(posedge clk_i);
    #10;
  endtask

  // Until the LSU model has popped every command
  task automatic wait_drained();
    int waited;
    waited = 0;
    @(negedge clk_i);
    while (lsu_valid_o) begin
      waited++;
      if (waited > WaitLimit) report_error("Timeout: the command queue never drained");
      @(negedge clk_i);
    end
    @(posedge clk_i);
    #10;
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) @(posedge clk_i);
    #10;
  endtask

  // Unit-stride: stop at transfer end, page end or 256 beats from the aligned start
  task automatic expect_unit(addr_t base, vl_t vl, vew_e vew, logic is_load);
    addr_t cur;
    addr_t last_byte;
    addr_t aligned;
    addr_t stop;
    cur       = base;
    last_byte = base + (addr_t'(vl) << vew) - addr_t'(1);
    while (cur <= last_byte) begin
      aligned = cur - (cur % BeatBytes);
      stop    = last_byte;
      if ((cur | addr_t'((1 << PageBits) - 1)) < stop) stop = cur | addr_t'((1 << PageBits) - 1);
      if (aligned + addr_t'(MaxBurstBeats * BeatBytes - 1) < stop) begin
        stop = aligned + addr_t'(MaxBurstBeats * BeatBytes - 1);
      end
      exp_log.push_back(make_access(cur, axi_len_t'((stop - aligned) / BeatBytes),
                                    axi_size_t'($clog2(BeatBytes)), is_load));
      cur = stop + addr_t'(1);
    end
  endtask

  // Strided: one single-beat element access per step
  task automatic expect_strided(addr_t base, vl_t vl, vew_e vew, stride_t stride, logic is_load);
    for (int k = 0; k < int'(vl); k++) begin
      exp_log.push_back(make_access(base + addr_t'(k * stride), '0, axi_size_t'(vew), is_load));
    end
  endtask

  `include "addrgen_checks.svh"

  // Watchdog for a stuck DUT or model
  initial begin
    repeat (WatchdogCycles) @(posedge clk_i);
    report_error("Watchdog timeout: the tests did not finish in time");
  end

  initial begin
    rst_ni            = 1'b0;
    pe_op_i           = OP_UNIT_LOAD;
    pe_addr_i         = '0;
    pe_vl_i           = '0;
    pe_stride_i       = '0;
    pe_vew_i          = EW8;
    pe_valid_i        = 1'b0;
    core_st_pending_i = 1'b0;
    repeat (ResetCycles) @(posedge clk_i);
    #10;
    rst_ni = 1'b1;
    wait_cycles(1);
    test_reset_state();
    test_unit_load();
    test_page_cross();
    test_burst_limit();
    test_strided_pending();
    test_misaligned();
    test_ordering();
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

// ==== rtl/addrgen_intf.sv ====
// Request from the instruction frontend to the burst planner
interface addrgen_req_if;
  import addrgen_pkg::*;

  // Instruction fields, stable while valid is high
  addr_t   addr;
  vl_t     len;
  stride_t stride;
  vew_e    vew;
  logic    is_load;
  // Unit-stride, becomes INCR bursts
  logic    is_burst;
  // Handshake, ready marks the last access
  logic    valid;
  logic    ready;

  modport frontend (
    output addr, len, stride, vew, is_load, is_burst, valid,
    input  ready
  );

  modport planner (
    input  addr, len, stride, vew, is_load, is_burst, valid,
    output ready
  );

endinterface

// Command from the burst planner into the load/store command queue
interface lsu_cmd_if;
  import addrgen_pkg::*;

  // One entry per AR/AW request
  addr_t     addr;
  axi_len_t  len;
  axi_size_t size;
  logic      is_load;
  // Only raised while full is low
  logic      push;
  // Queue status back to the planner
  logic      full;
  logic      empty;
  // Direction of the oldest entry
  logic      head_is_load;

  modport planner (
    output addr, len, size, is_load, push,
    input  full, empty, head_is_load
  );

  modport queue (
    input  addr, len, size, is_load, push,
    output full, empty, head_is_load
  );

endinterface

// ==== rtl/addrgen_pkg.sv ====
package addrgen_pkg;

  //////////////////////////////
  // Widths and limits
  //////////////////////////////

  // Byte address width
  localparam int unsigned AddrWidth     = 32;
  // Element count width
  localparam int unsigned VlWidth       = 12;
  // Offset bits inside a 4 KiB page
  localparam int unsigned PageBits      = 12;
  // AXI4 INCR burst limit
  localparam int unsigned MaxBurstBeats = 256;

  typedef logic        [AddrWidth-1:0] addr_t;
  typedef logic        [VlWidth-1:0]   vl_t;
  // Byte stride, may be negative
  typedef logic signed [AddrWidth-1:0] stride_t;
  // Beats minus one
  typedef logic        [7:0]           axi_len_t;
  // Log2 of the bytes per beat
  typedef logic        [2:0]           axi_size_t;

  //////////////////////////////
  // Encodings
  //////////////////////////////

  // Element width, value is log2 of the bytes
  typedef enum logic [1:0] {
    EW8  = 2'd0,
    EW16 = 2'd1,
    EW32 = 2'd2,
    EW64 = 2'd3
  } vew_e;

  // Vector memory operation
  typedef enum logic [1:0] {
    OP_UNIT_LOAD     = 2'd0,
    OP_UNIT_STORE    = 2'd1,
    OP_STRIDED_LOAD  = 2'd2,
    OP_STRIDED_STORE = 2'd3
  } mem_op_e;

  // Loads go out on AR, stores on AW
  function automatic logic op_is_load(mem_op_e op);
    return (op == OP_UNIT_LOAD) || (op == OP_STRIDED_LOAD);
  endfunction

  // Base must sit on an element boundary
  function automatic logic addr_misaligned(addr_t addr, vew_e vew);
    addr_t mask;
    mask = (addr_t'(1) << vew) - addr_t'(1);
    return |(addr & mask);
  endfunction

endpackage

// ==== rtl/burst_planner.sv ====
module burst_planner #(
  parameter int unsigned AxiDataWidth = 64
) (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  addrgen_req_if.planner         req,
  lsu_cmd_if.planner             cmd,
  // Scalar stores still draining in the core
  input  logic                   core_st_pending_i,
  // AR channel
  output addrgen_pkg::addr_t     ar_addr_o,
  output addrgen_pkg::axi_len_t  ar_len_o,
  output addrgen_pkg::axi_size_t ar_size_o,
  output logic                   ar_valid_o,
  input  logic                   ar_ready_i,
  // AW channel
  output addrgen_pkg::addr_t     aw_addr_o,
  output addrgen_pkg::axi_len_t  aw_len_o,
  output addrgen_pkg::axi_size_t aw_size_o,
  output logic                   aw_valid_o,
  input  logic                   aw_ready_i
);
  import addrgen_pkg::*;

  // Bus geometry
  localparam int unsigned BeatBytes     = AxiDataWidth / 8;
  localparam int unsigned BeatLog       = $clog2(BeatBytes);
  localparam addr_t       BeatMask      = addr_t'(BeatBytes - 1);
  localparam addr_t       MaxBurstBytes = addr_t'(MaxBurstBeats * BeatBytes);

  typedef enum logic [1:0] {
    IDLE,
    WAIT_STORES,
    REQUESTING
  } bp_state_e;

  bp_state_e state_q, state_d;

  // Running request
  addr_t   cur_addr_q;
  vl_t     remaining_q;
  // Last byte of the whole transfer
  addr_t   end_addr_q;
  stride_t stride_q;
  vew_e    vew_q;
  logic    is_load_q;
  logic    is_burst_q;

  // Per-access values
  addr_t     start_aligned;
  addr_t     page_last;
  addr_t     max_last;
  addr_t     burst_last;
  addr_t     next_addr;
  addr_t     covered;
  axi_len_t  ax_len;
  axi_size_t ax_size;
  logic      last;
  logic      take;
  logic      order_ok;
  logic      issue;
  logic      handshake;

  //////////////////////////////
  // Access shaping
  //////////////////////////////

  always_comb begin
    // Burst end is the earliest of transfer end, page end and 256 beats
    start_aligned = cur_addr_q & ~BeatMask;
    page_last     = {cur_addr_q[AddrWidth-1:PageBits], {PageBits{1'b1}}};
    max_last      = start_aligned + MaxBurstBytes - addr_t'(1);
    burst_last    = end_addr_q;
    if (page_last < burst_last) burst_last = page_last;
    if (max_last < burst_last) burst_last = max_last;

    if (is_burst_q) begin
      // Full-width INCR burst, next one starts bus aligned
      ax_len    = axi_len_t'((burst_last >> BeatLog) - (cur_addr_q >> BeatLog));
      ax_size   = axi_size_t'(BeatLog);
      next_addr = (burst_last & ~BeatMask) + addr_t'(BeatBytes);
      covered   = (burst_last - cur_addr_q + addr_t'(1)) >> vew_q;
    end else begin
      // One element per request
      ax_len    = '0;
      ax_size   = axi_size_t'(vew_q);
      next_addr = cur_addr_q + addr_t'(stride_q);
      covered   = addr_t'(1);
    end

    // This access finishes the instruction
    last = (addr_t'(remaining_q) <= covered);
  end

  //////////////////////////////
  // Handshakes
  //////////////////////////////

  assign take = (state_q == IDLE) && req.valid;

  // No direction switch while the other one is still queued
  assign order_ok = cmd.empty || (cmd.head_is_load == is_load_q);
  assign issue    = (state_q == REQUESTING) && !cmd.full && order_ok;

  assign ar_valid_o = issue && is_load_q;
  assign aw_valid_o = issue && !is_load_q;
  assign handshake  = (ar_valid_o && ar_ready_i) || (aw_valid_o && aw_ready_i);

  assign ar_addr_o = cur_addr_q;
  assign ar_len_o  = ax_len;
  assign ar_size_o = ax_size;
  assign aw_addr_o = cur_addr_q;
  assign aw_len_o  = ax_len;
  assign aw_size_o = ax_size;

  // Queue command mirrors the accepted request
  assign cmd.addr    = cur_addr_q;
  assign cmd.len     = ax_len;
  assign cmd.size    = ax_size;
  assign cmd.is_load = is_load_q;
  assign cmd.push    = handshake;

  assign req.ready = handshake && last;

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      IDLE:        if (take) state_d = core_st_pending_i ? WAIT_STORES : REQUESTING;
      WAIT_STORES: if (!core_st_pending_i) state_d = REQUESTING;
      REQUESTING:  if (handshake && last) state_d = IDLE;
      default:     state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (take) begin
      cur_addr_q  <= req.addr;
      remaining_q <= req.len;
      end_addr_q  <= req.addr + (addr_t'(req.len) << req.vew) - addr_t'(1);
      stride_q    <= req.stride;
      vew_q       <= req.vew;
      is_load_q   <= req.is_load;
      is_burst_q  <= req.is_burst;
    end else if (handshake) begin
      // Step to the next access
      cur_addr_q  <= next_addr;
      remaining_q <= remaining_q - vl_t'(covered);
    end
  end

  // Only one address channel active
  assert property (@(posedge clk_i) disable iff (!rst_ni) !(ar_valid_o && aw_valid_o));

  // Queue never overrun
  assert property (@(posedge clk_i) disable iff (!rst_ni) cmd.push |-> !cmd.full);

  // A stalled AR request keeps its fields
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    ar_valid_o && !ar_ready_i |=> ar_valid_o && $stable(ar_addr_o) && $stable(ar_len_o));

endmodule

// ==== rtl/insn_frontend.sv ====
module insn_frontend (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  // Instruction input
  input  addrgen_pkg::mem_op_e   pe_op_i,
  input  addrgen_pkg::addr_t     pe_addr_i,
  input  addrgen_pkg::vl_t       pe_vl_i,
  input  addrgen_pkg::stride_t   pe_stride_i,
  input  addrgen_pkg::vew_e      pe_vew_i,
  input  logic                   pe_valid_i,
  output logic                   pe_ready_o,
  // Request towards the planner
  addrgen_req_if.frontend        req,
  // Completion
  output logic                   ack_o,
  output logic                   exc_valid_o,
  output logic                   exc_load_o,
  output logic                   exc_store_o
);
  import addrgen_pkg::*;

  // IDLE waits, CHECK tests alignment, ISSUE waits for the planner
  typedef enum logic [1:0] {
    IDLE,
    CHECK,
    ISSUE
  } fe_state_e;

  fe_state_e state_q, state_d;

  // Held instruction
  mem_op_e op_q;
  addr_t   addr_q;
  vl_t     vl_q;
  stride_t stride_q;
  vew_e    vew_q;

  logic take;
  logic misaligned;
  logic is_load;
  logic done;

  // Accept only when nothing is in flight
  assign pe_ready_o = (state_q == IDLE);
  assign take       = pe_valid_i && pe_ready_o;

  // Alignment of the held base address
  assign misaligned = addr_misaligned(addr_q, vew_q);
  assign is_load    = op_is_load(op_q);

  // Request fields come straight from the held instruction
  assign req.addr     = addr_q;
  assign req.len      = vl_q;
  assign req.stride   = stride_q;
  assign req.vew      = vew_q;
  assign req.is_load  = is_load;
  assign req.is_burst = (op_q == OP_UNIT_LOAD) || (op_q == OP_UNIT_STORE);
  // Valid from the check cycle on, unless the base is bad
  assign req.valid    = ((state_q == CHECK) && !misaligned) || (state_q == ISSUE);

  // Planner finished the last access
  assign done = req.valid && req.ready;

  // Exception ack lasts the check cycle only
  assign exc_valid_o = (state_q == CHECK) && misaligned;
  assign exc_load_o  = exc_valid_o && is_load;
  assign exc_store_o = exc_valid_o && !is_load;
  assign ack_o       = exc_valid_o || done;

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      IDLE:    if (take) state_d = CHECK;
      CHECK:   state_d = misaligned ? IDLE : ISSUE;
      ISSUE:   state_d = ISSUE;
      default: state_d = IDLE;
    endcase
    // Back to idle once the planner is through
    if (done) state_d = IDLE;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Instruction capture on acceptance
  always_ff @(posedge clk_i) begin
    if (take) begin
      op_q     <= pe_op_i;
      addr_q   <= pe_addr_i;
      vl_q     <= pe_vl_i;
      stride_q <= pe_stride_i;
      vew_q    <= pe_vew_i;
    end
  end

  // Ack only closes a live instruction
  assert property (@(posedge clk_i) disable iff (!rst_ni) ack_o |-> (state_q != IDLE));

endmodule

// ==== rtl/lsu_cmd_queue.sv ====
module lsu_cmd_queue #(
  parameter int unsigned QueueDepth = 4
) (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  lsu_cmd_if.queue               cmd,
  // Either unit takes the head entry
  input  logic                   ldu_ready_i,
  input  logic                   stu_ready_i,
  output addrgen_pkg::addr_t     lsu_addr_o,
  output addrgen_pkg::axi_len_t  lsu_len_o,
  output addrgen_pkg::axi_size_t lsu_size_o,
  output logic                   lsu_is_load_o,
  output logic                   lsu_valid_o
);
  import addrgen_pkg::*;

  localparam int unsigned PtrWidth = (QueueDepth > 1) ? $clog2(QueueDepth) : 1;

  typedef logic [PtrWidth-1:0] ptr_t;
  typedef logic [PtrWidth:0]   cnt_t;

  // Entry storage
  addr_t     addr_mem [QueueDepth];
  axi_len_t  len_mem  [QueueDepth];
  axi_size_t size_mem [QueueDepth];
  logic      load_mem [QueueDepth];

  ptr_t wr_ptr_q;
  ptr_t rd_ptr_q;
  cnt_t count_q;
  logic full;
  logic empty;
  logic pop_req;
  logic pop;

  // Wrap at the last slot
  function automatic ptr_t next_ptr(ptr_t ptr);
    return (ptr == ptr_t'(QueueDepth - 1)) ? '0 : ptr + ptr_t'(1);
  endfunction

  assign empty   = (count_q == '0);
  assign full    = (count_q == cnt_t'(QueueDepth));
  assign pop_req = ldu_ready_i || stu_ready_i;
  assign pop     = pop_req && !empty;

  // Status back to the planner
  assign cmd.full         = full;
  assign cmd.empty        = empty;
  assign cmd.head_is_load = load_mem[rd_ptr_q];

  // Head entry
  assign lsu_addr_o    = addr_mem[rd_ptr_q];
  assign lsu_len_o     = len_mem[rd_ptr_q];
  assign lsu_size_o    = size_mem[rd_ptr_q];
  assign lsu_is_load_o = load_mem[rd_ptr_q];
  assign lsu_valid_o   = !empty;

  always_ff @(posedge clk_i) begin
    if (cmd.push) begin
      addr_mem[wr_ptr_q] <= cmd.addr;
      len_mem[wr_ptr_q]  <= cmd.len;
      size_mem[wr_ptr_q] <= cmd.size;
      load_mem[wr_ptr_q] <= cmd.is_load;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (cmd.push) wr_ptr_q <= next_ptr(wr_ptr_q);
      if (pop) rd_ptr_q <= next_ptr(rd_ptr_q);
      // Occupancy
      unique case ({cmd.push, pop})
        2'b10:   count_q <= count_q + cnt_t'(1);
        2'b01:   count_q <= count_q - cnt_t'(1);
        default: count_q <= count_q;
      endcase
    end
  end

  // Load and store units only pop a valid head
  assert property (@(posedge clk_i) disable iff (!rst_ni) pop_req |-> !empty);

endmodule

// ==== rtl/vldst_addrgen.sv ====
module vldst_addrgen #(
  parameter int unsigned AxiDataWidth = 64,
  parameter int unsigned QueueDepth   = 4
) (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  // Instruction input
  input  addrgen_pkg::mem_op_e   pe_op_i,
  input  addrgen_pkg::addr_t     pe_addr_i,
  input  addrgen_pkg::vl_t       pe_vl_i,
  input  addrgen_pkg::stride_t   pe_stride_i,
  input  addrgen_pkg::vew_e      pe_vew_i,
  input  logic                   pe_valid_i,
  output logic                   pe_ready_o,
  // AR channel
  output addrgen_pkg::addr_t     ar_addr_o,
  output addrgen_pkg::axi_len_t  ar_len_o,
  output addrgen_pkg::axi_size_t ar_size_o,
  output logic                   ar_valid_o,
  input  logic                   ar_ready_i,
  // AW channel
  output addrgen_pkg::addr_t     aw_addr_o,
  output addrgen_pkg::axi_len_t  aw_len_o,
  output addrgen_pkg::axi_size_t aw_size_o,
  output logic                   aw_valid_o,
  input  logic                   aw_ready_i,
  // Commands to the load/store units
  output addrgen_pkg::addr_t     lsu_addr_o,
  output addrgen_pkg::axi_len_t  lsu_len_o,
  output addrgen_pkg::axi_size_t lsu_size_o,
  output logic                   lsu_is_load_o,
  output logic                   lsu_valid_o,
  input  logic                   ldu_ready_i,
  input  logic                   stu_ready_i,
  // Completion
  output logic                   ack_o,
  output logic                   exc_valid_o,
  output logic                   exc_load_o,
  output logic                   exc_store_o,
  // Store drain
  input  logic                   core_st_pending_i
);

  // Frontend to planner, planner to queue
  addrgen_req_if req_if ();
  lsu_cmd_if     cmd_if ();

  insn_frontend u_frontend (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .pe_op_i     (pe_op_i),
    .pe_addr_i   (pe_addr_i),
    .pe_vl_i     (pe_vl_i),
    .pe_stride_i (pe_stride_i),
    .pe_vew_i    (pe_vew_i),
    .pe_valid_i  (pe_valid_i),
    .pe_ready_o  (pe_ready_o),
    .req         (req_if.frontend),
    .ack_o       (ack_o),
    .exc_valid_o (exc_valid_o),
    .exc_load_o  (exc_load_o),
    .exc_store_o (exc_store_o)
  );

  burst_planner #(
    .AxiDataWidth (AxiDataWidth)
  ) u_planner (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .req               (req_if.planner),
    .cmd               (cmd_if.planner),
    .core_st_pending_i (core_st_pending_i),
    .ar_addr_o         (ar_addr_o),
    .ar_len_o          (ar_len_o),
    .ar_size_o         (ar_size_o),
    .ar_valid_o        (ar_valid_o),
    .ar_ready_i        (ar_ready_i),
    .aw_addr_o         (aw_addr_o),
    .aw_len_o          (aw_len_o),
    .aw_size_o         (aw_size_o),
    .aw_valid_o        (aw_valid_o),
    .aw_ready_i        (aw_ready_i)
  );

  lsu_cmd_queue #(
    .QueueDepth (QueueDepth)
  ) u_queue (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .cmd           (cmd_if.queue),
    .ldu_ready_i   (ldu_ready_i),
    .stu_ready_i   (stu_ready_i),
    .lsu_addr_o    (lsu_addr_o),
    .lsu_len_o     (lsu_len_o),
    .lsu_size_o    (lsu_size_o),
    .lsu_is_load_o (lsu_is_load_o),
    .lsu_valid_o   (lsu_valid_o)
  );

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the testbench with Verilator, run it, and grep the log for the result

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
  --top-module tb_vldst_addrgen -f vldst_addrgen.f -o tb_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/tb_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
fi

if grep -q "All tests passed" "$LOG"; then
  echo "PASS"
  exit 0
else
  echo "FAIL"
  exit 1
fi

// ==== vldst_addrgen.f ====
+incdir+bench
rtl/addrgen_pkg.sv
rtl/addrgen_intf.sv
rtl/insn_frontend.sv
rtl/burst_planner.sv
rtl/lsu_cmd_queue.sv
rtl/vldst_addrgen.sv
bench/tb_vldst_addrgen.sv
